/* accum_warp_looper.f */
hdl/tau_cfg_pkg.sv
hdl/warp_offset_stage.sv
hdl/warp_index_stage.sv
hdl/warp_memofs_stage.sv
hdl/warp_vector_stage.sv
hdl/accum_warp_looper.sv
tb/accum_warp_looper_tb.sv

/* Makefile */
TOP := accum_warp_looper_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

obj_dir/V$(TOP): accum_warp_looper.f $(wildcard hdl/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f accum_warp_looper.f

lint:
	verilator --lint-only --timing -Wall --top-module accum_warp_looper \
		-f accum_warp_looper.f

clean:
	rm -rf obj_dir

/* tb/looper_golden.txt */
# C id linear shamt_x shamt_y substep | B bofs_x abeg_x aend_x abeg_y aend_y id_beg id_end bboundary_x
# E id addr0 addr1 addr2 addr3 valid retire | all fields hex, E lines follow their B line
C 0 1000 0 4 0001
C 1 2000 2 6 0004
C 2 fff0 1 8 0010
C 3 0400 3 5 6000
# Two by two offsets, ids 0 and 1, all lanes inside the boundary
B 00 0 2 0 2 0 2 40
E 0 1000 1001 1002 1003 f 0
E 1 2000 2004 2008 200c f 0
E 0 1001 1002 1003 1004 f 0
E 1 2004 2008 200c 2010 f 0
E 0 1010 1011 1012 1013 f 0
E 1 2040 2044 2048 204c f 0
E 0 1011 1012 1013 1014 f 0
E 1 2044 2048 204c 2050 f 1
# One offset, three ids, boundary cuts the warp after lane 1
B 3e 1 2 3 4 1 4 40
E 1 20c4 20c8 20cc 20d0 3 0
E 2 02f2 0302 0312 0322 3 0
E 3 0468 6468 c468 2468 3 1
# Offsets starting off zero, base wraps for id 2
B 10 2 4 6 8 2 4 13
E 2 05f4 0604 0614 0624 7 0
E 3 04d0 64d0 c4d0 24d0 7 0
E 2 05f6 0606 0616 0626 7 0
E 3 04d8 64d8 c4d8 24d8 7 0
E 2 06f4 0704 0714 0724 7 0
E 3 04f0 64f0 c4f0 24f0 7 0
E 2 06f6 0706 0716 0726 7 0
E 3 04f8 64f8 c4f8 24f8 7 1
# Single warp block at the top of the x range
B fe 0 1 0 1 3 4 ff
E 3 0400 6400 c400 2400 1 1

/* tb/accum_warp_looper_tb.sv */
`timescale 1ns/100ps

module accum_warp_looper_tb;
	import tau_cfg_pkg::*;

	localparam int MAX_BLK = 16;
	localparam int MAX_EXP = 256;
	// Idle cycles around each block
	localparam int GAP_CYCLES = 2;

	logic               i_clk;
	logic               i_reset;
	logic               i_abofs_rdy;
	logic               o_abofs_ack;
	logic [WBW-1:0]     i_bofs_x;
	logic [WBW-1:0]     i_abeg_x;
	logic [WBW-1:0]     i_aend_x;
	logic [WBW-1:0]     i_abeg_y;
	logic [WBW-1:0]     i_aend_y;
	logic [NCFG_BW-1:0] i_id_beg;
	logic [NCFG_BW-1:0] i_id_end;
	logic [ABW-1:0]     i_linears   [N_CFG];
	logic [SS_BW-1:0]   i_ashamt_x  [N_CFG];
	logic [SS_BW-1:0]   i_ashamt_y  [N_CFG];
	logic [ABW-1:0]     i_bsubsteps [N_CFG];
	logic [WBW-1:0]     i_bboundary_x;
	logic               o_addrval_rdy;
	logic               i_addrval_ack;
	logic [NCFG_BW-1:0] o_id;
	logic [ABW-1:0]     o_address [VSIZE];
	logic [VSIZE-1:0]   o_valid;
	logic               o_retire;

	// Golden data, one row per command and per expected warp
	logic [31:0] blk_cmd  [MAX_BLK][8];
	int          blk_nexp [MAX_BLK];
	logic [31:0] exp_warp [MAX_EXP][7];
	int          n_blk;
	int          n_exp;
	int          exp_next;

	int seed;
	int error_count;
	int cycle_count;
	int cycle_limit;

	// Last warp seen under back-pressure
	logic               hold_prev;
	logic [NCFG_BW-1:0] held_id;
	logic [ABW-1:0]     held_addr [VSIZE];
	logic [VSIZE-1:0]   held_valid;
	logic               held_retire;

	accum_warp_looper u_accum_warp_looper (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_abofs_rdy(i_abofs_rdy), .o_abofs_ack(o_abofs_ack),
		.i_bofs_x(i_bofs_x), .i_abeg_x(i_abeg_x), .i_aend_x(i_aend_x),
		.i_abeg_y(i_abeg_y), .i_aend_y(i_aend_y),
		.i_id_beg(i_id_beg), .i_id_end(i_id_end),
		.i_linears(i_linears), .i_ashamt_x(i_ashamt_x), .i_ashamt_y(i_ashamt_y),
		.i_bsubsteps(i_bsubsteps), .i_bboundary_x(i_bboundary_x),
		.o_addrval_rdy(o_addrval_rdy), .i_addrval_ack(i_addrval_ack),
		.o_id(o_id), .o_address(o_address), .o_valid(o_valid), .o_retire(o_retire)
	);

	always #5 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
		end
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			error_count++;
			abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected));
		end
	endtask

	function automatic logic draw_ack();
		int r;
		r = $random(seed);
		// Low about one cycle in three
		return (r % 3) != 0;
	endfunction

	task automatic load_golden();
		int          fd;
		int          code;
		logic [63:0] tag;
		string       skip;
		logic [31:0] v [8];
		fd = $fopen("tb/looper_golden.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open tb/looper_golden.txt for reading");
		end
		n_blk = 0;
		n_exp = 0;
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "#") begin
				code = $fgets(skip, fd);
			end else if (tag == "C") begin
				code = $fscanf(fd, "%h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]);
				if (code != 5 || v[0] >= N_CFG) begin
					abort_run("Malformed configuration line in golden file");
				end
				i_linears[v[0]]   = v[1][ABW-1:0];
				i_ashamt_x[v[0]]  = v[2][SS_BW-1:0];
				i_ashamt_y[v[0]]  = v[3][SS_BW-1:0];
				i_bsubsteps[v[0]] = v[4][ABW-1:0];
			end else if (tag == "B") begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
				if (code != 8 || n_blk >= MAX_BLK) begin
					abort_run("Malformed or surplus block line in golden file");
				end
				for (int i = 0; i < 8; i++) begin
					blk_cmd[n_blk][i] = v[i];
				end
				blk_nexp[n_blk] = 0;
				n_blk++;
			end else if (tag == "E") begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
				if (code != 7 || n_blk == 0 || n_exp >= MAX_EXP) begin
					abort_run("Malformed or misplaced warp line in golden file");
				end
				for (int i = 0; i < 7; i++) begin
					exp_warp[n_exp][i] = v[i];
				end
				blk_nexp[n_blk-1]++;
				n_exp++;
			end else begin
				abort_run("Unknown line type in golden file");
			end
		end
		$fclose(fd);
		if (n_blk == 0) begin
			abort_run("Golden file holds no block command");
		end
		for (int b = 0; b < n_blk; b++) begin
			if (blk_nexp[b] == 0) begin
				abort_run("A block in the golden file has no expected warp");
			end
		end
	endtask

	task automatic apply_command(input int b);
		i_abofs_rdy   = 1'b1;
		i_bofs_x      = blk_cmd[b][0][WBW-1:0];
		i_abeg_x      = blk_cmd[b][1][WBW-1:0];
		i_aend_x      = blk_cmd[b][2][WBW-1:0];
		i_abeg_y      = blk_cmd[b][3][WBW-1:0];
		i_aend_y      = blk_cmd[b][4][WBW-1:0];
		i_id_beg      = blk_cmd[b][5][NCFG_BW-1:0];
		i_id_end      = blk_cmd[b][6][NCFG_BW-1:0];
		i_bboundary_x = blk_cmd[b][7][WBW-1:0];
	endtask

	// Nothing may leave the looper between blocks
	task automatic idle_cycles(input int n);
		for (int g = 0; g < n; g++) begin
			@(negedge i_clk);
			i_abofs_rdy   = 1'b0;
			i_addrval_ack = draw_ack();
			#1;
			check_value(o_addrval_rdy, 1'b0, "warp presented with no block running");
			check_value(o_abofs_ack, 1'b0, "command ack with no block running");
		end
	endtask

	task automatic run_block(input int b);
		int   got;
		logic xfer;
		got       = 0;
		hold_prev = 1'b0;
		while (got < blk_nexp[b]) begin
			@(negedge i_clk);
			apply_command(b);
			i_addrval_ack = draw_ack();
			#1;
			if (hold_prev) begin
				check_value(o_addrval_rdy, 1'b1, "rdy dropped before its transfer");
				check_value(o_id, held_id, "held warp id changed");
				for (int k = 0; k < VSIZE; k++) begin
					check_value(o_address[k], held_addr[k], "held lane address changed");
				end
				check_value(o_valid, held_valid, "held valid mask changed");
				check_value(o_retire, held_retire, "held retire flag changed");
			end
			xfer = o_addrval_rdy && i_addrval_ack;
			// Only the last warp of the block closes the command
			check_value(o_abofs_ack, xfer && (got == blk_nexp[b] - 1), "command ack timing");
			if (xfer) begin
				check_value(o_id, exp_warp[exp_next][0], $sformatf("warp %0d id", exp_next));
				for (int k = 0; k < VSIZE; k++) begin
					check_value(o_address[k], exp_warp[exp_next][1+k],
						$sformatf("warp %0d lane %0d address", exp_next, k));
				end
				check_value(o_valid, exp_warp[exp_next][5],
					$sformatf("warp %0d valid mask", exp_next));
				check_value(o_retire, exp_warp[exp_next][6],
					$sformatf("warp %0d retire flag", exp_next));
				exp_next++;
				got++;
			end
			hold_prev   = o_addrval_rdy && !i_addrval_ack;
			held_id     = o_id;
			held_valid  = o_valid;
			held_retire = o_retire;
			for (int k = 0; k < VSIZE; k++) begin
				held_addr[k] = o_address[k];
			end
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		seed          = 32'hc1a9e477;
		error_count   = 0;
		cycle_count   = 0;
		cycle_limit   = 200;
		exp_next      = 0;
		hold_prev     = 1'b0;
		i_clk         = 1'b0;
		i_reset       = 1'b1;
		i_abofs_rdy   = 1'b0;
		i_addrval_ack = 1'b0;
		i_bofs_x      = '0;
		i_abeg_x      = '0;
		i_aend_x      = '0;
		i_abeg_y      = '0;
		i_aend_y      = '0;
		i_id_beg      = '0;
		i_id_end      = '0;
		i_bboundary_x = '0;
		for (int i = 0; i < N_CFG; i++) begin
			i_linears[i]   = '0;
			i_ashamt_x[i]  = '0;
			i_ashamt_y[i]  = '0;
			i_bsubsteps[i] = '0;
		end
		load_golden();
		cycle_limit = 40 * n_exp + 200;

		// Both handshake outputs stay low for the whole reset
		for (int i = 0; i < 10; i++) begin
			@(negedge i_clk);
			check_value(o_addrval_rdy, 1'b0, "warp rdy during reset");
			check_value(o_abofs_ack, 1'b0, "command ack during reset");
			i_addrval_ack = draw_ack();
		end
		i_reset = 1'b0;

		for (int b = 0; b < n_blk; b++) begin
			idle_cycles(GAP_CYCLES);
			run_block(b);
		end
		idle_cycles(GAP_CYCLES);

		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* hdl/accum_warp_looper.sv */
`timescale 1ns/100ps

module accum_warp_looper (
	input  logic                            i_clk,
	input  logic                            i_reset,
	// Command link
	input  logic                            i_abofs_rdy,
	output logic                            o_abofs_ack,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_bofs_x,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_abeg_x,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_aend_x,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_abeg_y,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_aend_y,
	input  logic [tau_cfg_pkg::NCFG_BW-1:0] i_id_beg,
	input  logic [tau_cfg_pkg::NCFG_BW-1:0] i_id_end,
	// Configuration
	input  logic [tau_cfg_pkg::ABW-1:0]     i_linears   [tau_cfg_pkg::N_CFG],
	input  logic [tau_cfg_pkg::SS_BW-1:0]   i_ashamt_x  [tau_cfg_pkg::N_CFG],
	input  logic [tau_cfg_pkg::SS_BW-1:0]   i_ashamt_y  [tau_cfg_pkg::N_CFG],
	input  logic [tau_cfg_pkg::ABW-1:0]     i_bsubsteps [tau_cfg_pkg::N_CFG],
	input  logic [tau_cfg_pkg::WBW-1:0]     i_bboundary_x,
	// Output link
	output logic                            o_addrval_rdy,
	input  logic                            i_addrval_ack,
	output logic [tau_cfg_pkg::NCFG_BW-1:0] o_id,
	output logic [tau_cfg_pkg::ABW-1:0]     o_address [tau_cfg_pkg::VSIZE],
	output logic [tau_cfg_pkg::VSIZE-1:0]   o_valid,
	output logic                            o_retire
);
	import tau_cfg_pkg::*;

	looper_state_e      state_r;
	looper_state_e      state_nxt;
	logic               start;
	logic               s0_done;
	logic               s4_fin;
	logic [WBW-1:0]     bofs_x_r;
	logic [NCFG_BW-1:0] id_beg_r;
	logic [NCFG_BW-1:0] id_end_r;

	logic               s12_rdy;
	logic               s12_ack;
	logic [WBW-1:0]     s12_aofs_x;
	logic [WBW-1:0]     s12_aofs_y;
	logic               s12_islast;
	logic               s23_rdy;
	logic               s23_ack;
	logic [NCFG_BW-1:0] s23_id;
	logic [WBW-1:0]     s23_aofs_x;
	logic [WBW-1:0]     s23_aofs_y;
	logic               s23_retire;
	logic               s34_rdy;
	logic               s34_ack;
	logic [NCFG_BW-1:0] s34_id;
	logic [ABW-1:0]     s34_linear;
	logic               s34_retire;

	// ==============================
	// Block state machine
	// ==============================

	assign start       = (state_r == LOOP_IDLE) && i_abofs_rdy;
	assign o_abofs_ack = s4_fin;

	always_comb begin
		state_nxt = state_r;
		case (state_r)
			LOOP_IDLE:  if (i_abofs_rdy) state_nxt = LOOP_RUN;
			// Last offset issued, chain still emptying
			LOOP_RUN:   if (s0_done) state_nxt = LOOP_DRAIN;
			LOOP_DRAIN: if (s4_fin) state_nxt = LOOP_IDLE;
			default:    state_nxt = LOOP_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state_r <= LOOP_IDLE;
		end else begin
			state_r <= state_nxt;
		end
	end

	// Command fields used past the start cycle
	always_ff @(posedge i_clk) begin
		if (start) begin
			bofs_x_r <= i_bofs_x;
			id_beg_r <= i_id_beg;
			id_end_r <= i_id_end;
		end
	end

	// ==============================
	// Stage chain
	// ==============================

	warp_offset_stage u_s0_ofs (
		.i_clk(i_clk), .i_reset(i_reset), .i_start(start),
		.i_abeg_x(i_abeg_x), .i_aend_x(i_aend_x),
		.i_abeg_y(i_abeg_y), .i_aend_y(i_aend_y),
		.o_dst_rdy(s12_rdy), .i_dst_ack(s12_ack),
		.o_aofs_x(s12_aofs_x), .o_aofs_y(s12_aofs_y),
		.o_islast(s12_islast), .o_done(s0_done)
	);

	warp_index_stage u_s1_idx (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_src_rdy(s12_rdy), .o_src_ack(s12_ack),
		.i_aofs_x(s12_aofs_x), .i_aofs_y(s12_aofs_y), .i_islast(s12_islast),
		.i_id_beg(id_beg_r), .i_id_end(id_end_r),
		.o_dst_rdy(s23_rdy), .i_dst_ack(s23_ack),
		.o_id(s23_id), .o_aofs_x(s23_aofs_x), .o_aofs_y(s23_aofs_y),
		.o_retire(s23_retire)
	);

	warp_memofs_stage u_s2_mofs (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_src_rdy(s23_rdy), .o_src_ack(s23_ack),
		.i_id(s23_id), .i_aofs_x(s23_aofs_x), .i_aofs_y(s23_aofs_y),
		.i_retire(s23_retire), .i_linears(i_linears),
		.i_ashamt_x(i_ashamt_x), .i_ashamt_y(i_ashamt_y),
		.o_dst_rdy(s34_rdy), .i_dst_ack(s34_ack),
		.o_id(s34_id), .o_linear(s34_linear), .o_retire(s34_retire)
	);

	warp_vector_stage u_s3_vofs (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_src_rdy(s34_rdy), .o_src_ack(s34_ack),
		.i_id(s34_id), .i_linear(s34_linear), .i_retire(s34_retire),
		.i_bofs_x(bofs_x_r), .i_bboundary_x(i_bboundary_x),
		.i_bsubsteps(i_bsubsteps),
		.o_dst_rdy(o_addrval_rdy), .i_dst_ack(i_addrval_ack),
		.o_id(o_id), .o_address(o_address), .o_valid(o_valid),
		.o_retire(o_retire), .o_fin(s4_fin)
	);

	// Retire only surfaces after the offset stage has finished the block
	a_fin_in_drain: assert property (@(posedge i_clk) disable iff (i_reset)
		s4_fin |-> (state_r == LOOP_DRAIN));

	// Command stays presented until its ack
	a_cmd_held: assert property (@(posedge i_clk) disable iff (i_reset)
		(state_r != LOOP_IDLE) |-> i_abofs_rdy);

endmodule

/* hdl/warp_vector_stage.sv */
`timescale 1ns/100ps

module warp_vector_stage (
	input  logic                            i_clk,
	input  logic                            i_reset,
	input  logic                            i_src_rdy,
	output logic                            o_src_ack,
	input  logic [tau_cfg_pkg::NCFG_BW-1:0] i_id,
	input  logic [tau_cfg_pkg::ABW-1:0]     i_linear,
	input  logic                            i_retire,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_bofs_x,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_bboundary_x,
	input  logic [tau_cfg_pkg::ABW-1:0]     i_bsubsteps [tau_cfg_pkg::N_CFG],
	output logic                            o_dst_rdy,
	input  logic                            i_dst_ack,
	output logic [tau_cfg_pkg::NCFG_BW-1:0] o_id,
	output logic [tau_cfg_pkg::ABW-1:0]     o_address [tau_cfg_pkg::VSIZE],
	output logic [tau_cfg_pkg::VSIZE-1:0]   o_valid,
	output logic                            o_retire,
	output logic                            o_fin
);
	import tau_cfg_pkg::*;

	// ==============================
	// Lane expansion
	// ==============================

	logic [CFG_SEL_BW-1:0] sel;
	logic [ABW-1:0]        substep;
	logic [ABW-1:0]        lane_addr [VSIZE];
	logic [WBW:0]          lane_x    [VSIZE];
	logic [VSIZE-1:0]      lane_valid;
	logic                  load;

	assign sel     = i_id[CFG_SEL_BW-1:0];
	assign substep = i_bsubsteps[sel];

	// Each lane sits one substep above the previous one
	always_comb begin
		lane_addr[0] = i_linear;
		for (int k = 1; k < VSIZE; k++) begin
			lane_addr[k] = lane_addr[k-1] + substep;
		end
	end

	// Boundary check runs one bit wider so bofs+k cannot wrap
	always_comb begin
		for (int k = 0; k < VSIZE; k++) begin
			lane_x[k]     = {1'b0, i_bofs_x} + (WBW+1)'(k);
			lane_valid[k] = (lane_x[k] < {1'b0, i_bboundary_x});
		end
	end

	// ==============================
	// Output register
	// ==============================

	assign load      = i_src_rdy && (!o_dst_rdy || i_dst_ack);
	assign o_src_ack = load;

	// Final warp of the block leaves this cycle
	assign o_fin = o_dst_rdy && i_dst_ack && o_retire;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_dst_rdy <= 1'b0;
		end else if (load) begin
			o_dst_rdy <= 1'b1;
		end else if (o_dst_rdy && i_dst_ack) begin
			o_dst_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			o_id     <= i_id;
			o_valid  <= lane_valid;
			o_retire <= i_retire;
			for (int k = 0; k < VSIZE; k++) begin
				o_address[k] <= lane_addr[k];
			end
		end
	end

endmodule

/* hdl/warp_memofs_stage.sv */
`timescale 1ns/100ps

module warp_memofs_stage (
	input  logic                            i_clk,
	input  logic                            i_reset,
	input  logic                            i_src_rdy,
	output logic                            o_src_ack,
	input  logic [tau_cfg_pkg::NCFG_BW-1:0] i_id,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_aofs_x,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_aofs_y,
	input  logic                            i_retire,
	input  logic [tau_cfg_pkg::ABW-1:0]     i_linears  [tau_cfg_pkg::N_CFG],
	input  logic [tau_cfg_pkg::SS_BW-1:0]   i_ashamt_x [tau_cfg_pkg::N_CFG],
	input  logic [tau_cfg_pkg::SS_BW-1:0]   i_ashamt_y [tau_cfg_pkg::N_CFG],
	output logic                            o_dst_rdy,
	input  logic                            i_dst_ack,
	output logic [tau_cfg_pkg::NCFG_BW-1:0] o_id,
	output logic [tau_cfg_pkg::ABW-1:0]     o_linear,
	output logic                            o_retire
);
	import tau_cfg_pkg::*;

	// ==============================
	// Address arithmetic
	// ==============================

	logic [CFG_SEL_BW-1:0] sel;
	logic [ABW-1:0]        base;
	logic [SS_BW-1:0]      shamt_x;
	logic [SS_BW-1:0]      shamt_y;
	logic [ABW-1:0]        term_x;
	logic [ABW-1:0]        term_y;
	logic [ABW-1:0]        linear;
	logic                  load;

	// Per-id table lookup
	assign sel     = i_id[CFG_SEL_BW-1:0];
	assign base    = i_linears[sel];
	assign shamt_x = i_ashamt_x[sel];
	assign shamt_y = i_ashamt_y[sel];

	// Strides are powers of two so each axis is a shift
	assign term_x = ABW'(i_aofs_x) << shamt_x;
	assign term_y = ABW'(i_aofs_y) << shamt_y;

	// Wraps modulo 2^ABW
	assign linear = base + term_x + term_y;

	// ==============================
	// Output register
	// ==============================

	assign load      = i_src_rdy && (!o_dst_rdy || i_dst_ack);
	assign o_src_ack = load;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_dst_rdy <= 1'b0;
		end else if (load) begin
			o_dst_rdy <= 1'b1;
		end else if (o_dst_rdy && i_dst_ack) begin
			o_dst_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			o_id     <= i_id;
			o_linear <= linear;
			o_retire <= i_retire;
		end
	end

	// Ids come from the command range and must index the table
	a_id_in_table: assert property (@(posedge i_clk) disable iff (i_reset)
		i_src_rdy |-> (i_id < NCFG_BW'(N_CFG)));

endmodule

/* hdl/warp_index_stage.sv */
`timescale 1ns/100ps

module warp_index_stage (
	input  logic                            i_clk,
	input  logic                            i_reset,
	input  logic                            i_src_rdy,
	output logic                            o_src_ack,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_aofs_x,
	input  logic [tau_cfg_pkg::WBW-1:0]     i_aofs_y,
	input  logic                            i_islast,
	input  logic [tau_cfg_pkg::NCFG_BW-1:0] i_id_beg,
	input  logic [tau_cfg_pkg::NCFG_BW-1:0] i_id_end,
	output logic                            o_dst_rdy,
	input  logic                            i_dst_ack,
	output logic [tau_cfg_pkg::NCFG_BW-1:0] o_id,
	output logic [tau_cfg_pkg::WBW-1:0]     o_aofs_x,
	output logic [tau_cfg_pkg::WBW-1:0]     o_aofs_y,
	output logic                            o_retire
);
	import tau_cfg_pkg::*;

	// Set while an offset is partway through its ids
	logic               mid_r;
	logic [NCFG_BW-1:0] nxt_id_r;
	logic [NCFG_BW-1:0] cur_id;
	logic [NCFG_BW-1:0] last_id;
	logic               is_last_id;
	logic               load;

	assign cur_id     = mid_r ? nxt_id_r : i_id_beg;
	assign last_id    = i_id_end - 1'b1;
	assign is_last_id = (cur_id == last_id);

	// Register free or being emptied this cycle
	assign load = i_src_rdy && (!o_dst_rdy || i_dst_ack);

	// The offset is consumed together with its final id
	assign o_src_ack = load && is_last_id;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_dst_rdy <= 1'b0;
			mid_r     <= 1'b0;
		end else begin
			if (load) begin
				o_dst_rdy <= 1'b1;
				mid_r     <= !is_last_id;
			end else if (o_dst_rdy && i_dst_ack) begin
				o_dst_rdy <= 1'b0;
			end
		end
	end

	// Payload
	always_ff @(posedge i_clk) begin
		if (load) begin
			nxt_id_r <= cur_id + 1'b1;
			o_id     <= cur_id;
			o_aofs_x <= i_aofs_x;
			o_aofs_y <= i_aofs_y;
			o_retire <= i_islast && is_last_id;
		end
	end

	// An empty id range would wrap the id counter forever
	a_id_nonempty: assert property (@(posedge i_clk) disable iff (i_reset)
		i_src_rdy |-> (i_id_beg < i_id_end));

endmodule

/* hdl/warp_offset_stage.sv */
`timescale 1ns/100ps

module warp_offset_stage (
	input  logic                        i_clk,
	input  logic                        i_reset,
	input  logic                        i_start,
	input  logic [tau_cfg_pkg::WBW-1:0] i_abeg_x,
	input  logic [tau_cfg_pkg::WBW-1:0] i_aend_x,
	input  logic [tau_cfg_pkg::WBW-1:0] i_abeg_y,
	input  logic [tau_cfg_pkg::WBW-1:0] i_aend_y,
	output logic                        o_dst_rdy,
	input  logic                        i_dst_ack,
	output logic [tau_cfg_pkg::WBW-1:0] o_aofs_x,
	output logic [tau_cfg_pkg::WBW-1:0] o_aofs_y,
	output logic                        o_islast,
	output logic                        o_done
);
	import tau_cfg_pkg::*;

	// ==============================
	// Range and current corner
	// ==============================

	logic [WBW-1:0] in_beg [VDIM];
	logic [WBW-1:0] in_end [VDIM];
	logic [WBW-1:0] beg_r  [VDIM];
	logic [WBW-1:0] end_r  [VDIM];
	logic [WBW-1:0] cur_r  [VDIM];
	logic [WBW-1:0] inc    [VDIM];
	logic [WBW-1:0] nxt    [VDIM];
	logic [VDIM-1:0] at_end;
	logic [VDIM:0]   carry;
	logic xfer;

	always_comb begin
		in_beg[0] = i_abeg_x;
		in_beg[1] = i_abeg_y;
		in_end[0] = i_aend_x;
		in_end[1] = i_aend_y;
	end

	// Ripple carry across axes, x steps fastest
	always_comb begin
		carry[0] = 1'b1;
		for (int i = 0; i < VDIM; i++) begin
			inc[i] = cur_r[i] + 1'b1;
			at_end[i] = (inc[i] == end_r[i]);
			if (carry[i]) begin
				nxt[i] = at_end[i] ? beg_r[i] : inc[i];
			end else begin
				nxt[i] = cur_r[i];
			end
			carry[i+1] = carry[i] && at_end[i];
		end
	end

	assign xfer     = o_dst_rdy && i_dst_ack;
	// Every axis sits on its last value
	assign o_islast = carry[VDIM];
	assign o_done   = xfer && o_islast;
	assign o_aofs_x = cur_r[0];
	assign o_aofs_y = cur_r[1];

	// ==============================
	// Control
	// ==============================

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_dst_rdy <= 1'b0;
		end else if (i_start && !o_dst_rdy) begin
			o_dst_rdy <= 1'b1;
		end else if (xfer && o_islast) begin
			o_dst_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start && !o_dst_rdy) begin
			for (int i = 0; i < VDIM; i++) begin
				beg_r[i] <= in_beg[i];
				end_r[i] <= in_end[i];
				cur_r[i] <= in_beg[i];
			end
		end else if (xfer) begin
			for (int i = 0; i < VDIM; i++) begin
				cur_r[i] <= nxt[i];
			end
		end
	end

	// The top only starts a block once the previous one has drained
	a_start_idle: assert property (@(posedge i_clk) disable iff (i_reset)
		i_start |-> !o_dst_rdy);

	// Empty ranges would never reach the last corner
	a_range_nonempty: assert property (@(posedge i_clk) disable iff (i_reset)
		i_start |-> (i_abeg_x < i_aend_x) && (i_abeg_y < i_aend_y));

endmodule

/* hdl/tau_cfg_pkg.sv */
package tau_cfg_pkg;

	// ==============================
	// Geometry
	// ==============================

	// Accumulation axes x and y
	localparam int VDIM = 2;

	// One offset coordinate
	localparam int WBW = 8;

	// Linear memory address
	localparam int ABW = 16;

	// Lanes per warp
	localparam int VSIZE = 4;

	// ==============================
	// Configuration table
	// ==============================

	localparam int N_CFG = 4;

	// Holds N_CFG itself as an exclusive end
	localparam int NCFG_BW = 3;

	// Index into the per-id tables
	localparam int CFG_SEL_BW = $clog2(N_CFG);

	// Stride shift amount
	localparam int SS_BW = 4;

	// Block state of the looper top
	typedef enum logic [1:0] {LOOP_IDLE, LOOP_RUN, LOOP_DRAIN} looper_state_e;

endpackage
